// File: common/ex_pkg.sv
// shared word and index types, alu op and multiplier state enums, opcode and funct constants
`default_nettype none

package ex_pkg;

    // data word, also used for the raw instruction
    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // width of a word, the multiplier runs at most this many steps
    localparam int WORD_BITS = 32;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct7 field values
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 field values, shared by reg-reg and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire

// File: list.f
common/ex_pkg.sv
src/ex_decoder.sv
src/reg_file.sv
src/alu.sv
mul_unit/mul_control.sv
mul_unit/mul_counter.sv
mul_unit/mul_datapath.sv
src/execute_stage.sv
verification/tb_execute_stage.sv

// File: mul_unit/mul_control.sv
// multiplier fsm, sequences load, steps and the done handshake
`default_nettype none

module mul_control (
    input  logic CLK,
    input  logic nRST,
    input  logic mul_start,
    input  logic mul_ack,
    input  logic last_step,
    input  logic mplier_zero,
    output logic mul_busy,
    output logic load,
    output logic step
);

    ex_pkg::mul_state_t state;
    ex_pkg::mul_state_t state_n;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ex_pkg::MUL_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n  = state;
        load     = 1'b0;
        step     = 1'b0;
        mul_busy = 1'b0;
        case (state)
            ex_pkg::MUL_IDLE: begin
                // busy already in the cycle the mul shows up
                mul_busy = mul_start;
                if (mul_start) begin
                    load    = 1'b1;
                    state_n = ex_pkg::MUL_RUN;
                end
            end
            ex_pkg::MUL_RUN: begin
                mul_busy = 1'b1;
                step     = 1'b1;
                // stop early once no multiplier bits are left
                if (last_step || mplier_zero) begin
                    state_n = ex_pkg::MUL_DONE;
                end
            end
            ex_pkg::MUL_DONE: begin
                // product held until the pipeline register takes it
                if (mul_ack) begin
                    state_n = ex_pkg::MUL_IDLE;
                end
            end
            default: begin
                state_n = ex_pkg::MUL_IDLE;
            end
        endcase
    end

    // fetch keeps the mul in place while the steps run
    a_start_held: assert property (
        @(posedge CLK) disable iff (!nRST) (state == ex_pkg::MUL_RUN) |-> mul_start
    );

    // execute stage may only ack a finished product
    a_ack_in_done: assert property (
        @(posedge CLK) disable iff (!nRST) mul_ack |-> (state == ex_pkg::MUL_DONE)
    );

endmodule

`default_nettype wire

// File: mul_unit/mul_counter.sv
// step counter for the multiplier, flags the last iteration
`default_nettype none

module mul_counter (
    input  logic CLK,
    input  logic nRST,
    input  logic load,
    input  logic step,
    output logic last_step
);

    // must hold WORD_BITS itself
    localparam int CNT_W = $clog2(ex_pkg::WORD_BITS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(ex_pkg::WORD_BITS);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    // one step left
    assign last_step = (count == CNT_W'(1));

    a_no_step_at_zero: assert property (
        @(posedge CLK) disable iff (!nRST) step |-> (count != '0)
    );

endmodule

`default_nettype wire

// File: mul_unit/mul_datapath.sv
// shift-add multiplier datapath, multiplicand, multiplier and accumulator
`default_nettype none

module mul_datapath (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          load,
    input  logic          step,
    input  ex_pkg::word_t mul_a,
    input  ex_pkg::word_t mul_b,
    output ex_pkg::word_t mul_product,
    output logic          mplier_zero
);

    ex_pkg::word_t mcand;
    ex_pkg::word_t mplier;
    ex_pkg::word_t acc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (load) begin
            // operands latched here, forwarding may change afterwards
            mcand  <= mul_a;
            mplier <= mul_b;
            acc    <= '0;
        end else if (step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // low word only, upper bits wrap away
    assign mul_product = acc;

    // nothing above the current bit, this step is the last useful one
    assign mplier_zero = (mplier[31:1] == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with verilator and runs it
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_execute_stage -f list.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "simulation did not pass"; exit 1; }

// File: src/alu.sv
// single-cycle integer alu for the base reg-reg and immediate operations
`default_nettype none

module alu (
    input  ex_pkg::alu_op_t alu_op,
    input  ex_pkg::word_t   port_a,
    input  ex_pkg::word_t   port_b,
    output ex_pkg::word_t   port_out
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = port_b[4:0];

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD:  port_out = port_a + port_b;
            ex_pkg::ALU_SUB:  port_out = port_a - port_b;
            ex_pkg::ALU_SLL:  port_out = port_a << shamt;
            ex_pkg::ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ex_pkg::ALU_SLTU: port_out = {31'b0, port_a < port_b};
            ex_pkg::ALU_XOR:  port_out = port_a ^ port_b;
            ex_pkg::ALU_SRL:  port_out = port_a >> shamt;
            // arithmetic shift keeps the sign
            ex_pkg::ALU_SRA:  port_out = $unsigned($signed(port_a) >>> shamt);
            ex_pkg::ALU_OR:   port_out = port_a | port_b;
            ex_pkg::ALU_AND:  port_out = port_a & port_b;
            default:          port_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/ex_decoder.sv
// instruction decoder for the rv32 alu subset, lui and mul
`default_nettype none

module ex_decoder #(
    parameter int NUM_REGS = 32
) (
    input  ex_pkg::word_t    instr,
    output ex_pkg::reg_idx_t rs1,
    output ex_pkg::reg_idx_t rs2,
    output ex_pkg::reg_idx_t rd,
    output ex_pkg::alu_op_t  alu_op,
    output ex_pkg::word_t    imm,
    output logic             use_imm,
    output logic             is_lui,
    output logic             reg_write,
    output logic             is_mul,
    output logic             illegal
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    ex_pkg::word_t   imm_i;
    ex_pkg::word_t   imm_u;
    ex_pkg::word_t   shamt;
    ex_pkg::alu_op_t base_op;
    logic            bad_op;
    logic            uses_rs1;
    logic            uses_rs2;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // sign-extended i-type, u-type with low bits zero
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    // shift amount sits where rs2 would be
    assign shamt = {27'b0, instr[24:20]};

    // funct3 to alu op, alt forms patched below
    always_comb begin
        case (funct3)
            ex_pkg::F3_ADD:  base_op = ex_pkg::ALU_ADD;
            ex_pkg::F3_SLL:  base_op = ex_pkg::ALU_SLL;
            ex_pkg::F3_SLT:  base_op = ex_pkg::ALU_SLT;
            ex_pkg::F3_SLTU: base_op = ex_pkg::ALU_SLTU;
            ex_pkg::F3_XOR:  base_op = ex_pkg::ALU_XOR;
            ex_pkg::F3_SR:   base_op = ex_pkg::ALU_SRL;
            ex_pkg::F3_OR:   base_op = ex_pkg::ALU_OR;
            default:         base_op = ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        alu_op   = base_op;
        imm      = imm_i;
        use_imm  = 1'b0;
        is_lui   = 1'b0;
        is_mul   = 1'b0;
        bad_op   = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            ex_pkg::OPC_OP: begin
                uses_rs2 = 1'b1;
                if (funct7 == ex_pkg::FUNCT7_MULDIV) begin
                    // only mul of the m extension
                    is_mul = 1'b1;
                    bad_op = (funct3 != ex_pkg::F3_ADD);
                end else if (funct7 == ex_pkg::FUNCT7_ALT) begin
                    if (funct3 == ex_pkg::F3_ADD) begin
                        alu_op = ex_pkg::ALU_SUB;
                    end else if (funct3 == ex_pkg::F3_SR) begin
                        alu_op = ex_pkg::ALU_SRA;
                    end else begin
                        bad_op = 1'b1;
                    end
                end else if (funct7 != ex_pkg::FUNCT7_BASE) begin
                    bad_op = 1'b1;
                end
            end
            ex_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == ex_pkg::F3_SLL) begin
                    imm    = shamt;
                    bad_op = (funct7 != ex_pkg::FUNCT7_BASE);
                end else if (funct3 == ex_pkg::F3_SR) begin
                    imm = shamt;
                    if (funct7 == ex_pkg::FUNCT7_ALT) begin
                        alu_op = ex_pkg::ALU_SRA;
                    end else begin
                        bad_op = (funct7 != ex_pkg::FUNCT7_BASE);
                    end
                end
            end
            ex_pkg::OPC_LUI: begin
                // 0 + imm_u through the adder
                alu_op   = ex_pkg::ALU_ADD;
                imm      = imm_u;
                use_imm  = 1'b1;
                is_lui   = 1'b1;
                uses_rs1 = 1'b0;
            end
            default: begin
                bad_op   = 1'b1;
                uses_rs1 = 1'b0;
            end
        endcase
    end

    // register indices beyond the file count as illegal too
    assign illegal = bad_op
                   || (rd >= NUM_REGS)
                   || (uses_rs1 && (rs1 >= NUM_REGS))
                   || (uses_rs2 && (rs2 >= NUM_REGS));

    // no write for illegal or x0
    assign reg_write = !illegal && (rd != '0);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// execute stage top, forwarding, operand select, alu and multiplier, ex/mem register
`default_nettype none

module execute_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic             CLK,
    input  logic             nRST,
    input  ex_pkg::word_t    instr,
    input  logic             instr_valid,
    input  logic             stall,
    input  logic             flush,
    input  logic             wb_en,
    input  ex_pkg::reg_idx_t wb_rd,
    input  ex_pkg::word_t    wb_data,
    output logic             busy,
    output logic             ex_valid,
    output logic             ex_reg_write,
    output logic             ex_illegal,
    output ex_pkg::reg_idx_t ex_rd,
    output ex_pkg::word_t    ex_result
);

    // decode
    ex_pkg::reg_idx_t rs1;
    ex_pkg::reg_idx_t rs2;
    ex_pkg::reg_idx_t rd;
    ex_pkg::alu_op_t  alu_op;
    ex_pkg::word_t    imm;
    logic             use_imm;
    logic             is_lui;
    logic             reg_write;
    logic             is_mul;
    logic             illegal;

    // operands
    ex_pkg::word_t    rs1_data;
    ex_pkg::word_t    rs2_data;
    ex_pkg::word_t    rs1_fwd;
    ex_pkg::word_t    rs2_fwd;
    ex_pkg::word_t    port_a;
    ex_pkg::word_t    port_b;
    ex_pkg::word_t    alu_out;
    ex_pkg::word_t    ex_out;

    // multiplier
    logic             mul_start;
    logic             mul_ack;
    logic             mul_busy;
    logic             mul_load;
    logic             mul_step;
    logic             last_step;
    logic             mplier_zero;
    ex_pkg::word_t    mul_product;

    ex_decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
        .instr,
        .rs1,
        .rs2,
        .rd,
        .alu_op,
        .imm,
        .use_imm,
        .is_lui,
        .reg_write,
        .is_mul,
        .illegal
    );

    // write port comes from the later stage
    reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
        .CLK,
        .nRST,
        .rs1,
        .rs2,
        .wr_en   (wb_en),
        .wr_idx  (wb_rd),
        .wr_data (wb_data),
        .rs1_data,
        .rs2_data
    );

    // writeback bypass, same edge as the regfile write
    assign rs1_fwd = (wb_en && (wb_rd == rs1) && (wb_rd != '0)) ? wb_data : rs1_data;
    assign rs2_fwd = (wb_en && (wb_rd == rs2) && (wb_rd != '0)) ? wb_data : rs2_data;

    // lui adds its immediate to zero
    assign port_a = is_lui ? '0 : rs1_fwd;
    assign port_b = use_imm ? imm : rs2_fwd;

    alu u_alu (
        .alu_op,
        .port_a,
        .port_b,
        .port_out (alu_out)
    );

    assign mul_start = instr_valid && is_mul && !illegal;
    // start still high but not busy means the product is ready
    assign mul_ack   = mul_start && !mul_busy && !stall;

    mul_control u_mul_control (
        .CLK,
        .nRST,
        .mul_start,
        .mul_ack,
        .last_step,
        .mplier_zero,
        .mul_busy,
        .load (mul_load),
        .step (mul_step)
    );

    mul_counter u_mul_counter (
        .CLK,
        .nRST,
        .load (mul_load),
        .step (mul_step),
        .last_step
    );

    mul_datapath u_mul_datapath (
        .CLK,
        .nRST,
        .load  (mul_load),
        .step  (mul_step),
        .mul_a (rs1_fwd),
        .mul_b (rs2_fwd),
        .mul_product,
        .mplier_zero
    );

    assign ex_out = is_mul ? mul_product : alu_out;
    // fetch holds the instruction while this is high
    assign busy   = mul_busy;

    // ex/mem register, stall over flush over bubble
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_illegal   <= 1'b0;
            ex_rd        <= '0;
            ex_result    <= '0;
        end else if (!stall) begin
            if (flush) begin
                ex_valid     <= 1'b0;
                ex_reg_write <= 1'b0;
                ex_illegal   <= 1'b0;
                ex_rd        <= '0;
                ex_result    <= '0;
            end else if (busy) begin
                // bubble while the multiplier runs
                ex_valid     <= 1'b0;
                ex_reg_write <= 1'b0;
                ex_illegal   <= 1'b0;
            end else begin
                ex_valid     <= instr_valid;
                ex_reg_write <= instr_valid && reg_write;
                ex_illegal   <= instr_valid && illegal;
                ex_rd        <= rd;
                ex_result    <= ex_out;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
// register file, two async read ports, one write port, x0 tied to zero
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic             CLK,
    input  logic             nRST,
    input  ex_pkg::reg_idx_t rs1,
    input  ex_pkg::reg_idx_t rs2,
    input  logic             wr_en,
    input  ex_pkg::reg_idx_t wr_idx,
    input  ex_pkg::word_t    wr_data,
    output ex_pkg::word_t    rs1_data,
    output ex_pkg::word_t    rs2_data
);

    localparam int IDX_W = $clog2(NUM_REGS);

    ex_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0) && (wr_idx < NUM_REGS)) begin
            regs[wr_idx[IDX_W-1:0]] <= wr_data;
        end
    end

    // out of range reads give zero, decoder flags them
    assign rs1_data = (rs1 < NUM_REGS) ? regs[rs1[IDX_W-1:0]] : '0;
    assign rs2_data = (rs2 < NUM_REGS) ? regs[rs2[IDX_W-1:0]] : '0;

    // later stage must never target a missing register
    a_wr_idx_range: assert property (
        @(posedge CLK) disable iff (!nRST) wr_en |-> (wr_idx < NUM_REGS)
    );

endmodule

`default_nettype wire

// File: verification/tb_execute_stage.sv
// testbench for execute_stage with register model, reference function, compare process and timeout
`default_nettype none

module tb_execute_stage;

    // rv32 encodings used by the stimulus and the reference
    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    localparam int NUM_FIXED   = 6;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_INSTR   = NUM_FIXED + NUM_RANDOM;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR + 100;
    // one load cycle plus at most one step per multiplier bit
    localparam int MUL_BUSY_MAX = 33;

    logic        CLK;
    logic        nRST;
    logic [31:0] instr;
    logic        instr_valid;
    logic        stall;
    logic        flush;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        busy;
    logic        ex_valid;
    logic        ex_reg_write;
    logic        ex_illegal;
    logic [4:0]  ex_rd;
    logic [31:0] ex_result;

    // expected contents of the ex/mem register
    logic        exp_valid;
    logic        exp_rw;
    logic        exp_ill;
    logic [4:0]  exp_rd;
    logic [31:0] exp_res;
    logic        exp_res_known;
    string       exp_name = "reset";

    logic [31:0] model [32];
    logic [31:0] prog [$];
    logic [31:0] seed = 32'd35;
    logic        checking = 1'b0;
    logic        mul_first;
    int          busy_cycles;
    int          stall_left;
    int          cycle_count = 0;
    // writeback values for the later stage, applied at the edge
    logic        wb_next_en;
    logic [4:0]  wb_next_rd;
    logic [31:0] wb_next_data;

    execute_stage #(.NUM_REGS(32)) DUT (
        .CLK,
        .nRST,
        .instr,
        .instr_valid,
        .stall,
        .flush,
        .wb_en,
        .wb_rd,
        .wb_data,
        .busy,
        .ex_valid,
        .ex_reg_write,
        .ex_illegal,
        .ex_rd,
        .ex_result
    );

    always #10 CLK = ~CLK;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s %s expected %h actual %h",
                               exp_name, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // two lcg steps, high halves only
    task automatic next_rand(output logic [31:0] r);
        seed = lcg(seed);
        r[31:16] = seed[31:16];
        seed = lcg(seed);
        r[15:0] = seed[31:16];
    endtask

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic is_mul_op(input logic [31:0] ins);
        return (ins[6:0] == OPC_OP) && (ins[31:25] == F7_MUL);
    endfunction

    function automatic logic is_legal(input logic [31:0] ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        if (ins[6:0] == OPC_LUI) return 1'b1;
        if (ins[6:0] == OPC_OP) begin
            return (f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == 3'd0 || f3 == 3'd5))
                || ((f7 == F7_MUL) && (f3 == 3'd0));
        end
        if (ins[6:0] == OPC_IMM) begin
            // shift immediates carry a funct7 in the upper bits
            if (f3 == 3'd1) return f7 == F7_BASE;
            if (f3 == 3'd5) return (f7 == F7_BASE) || (f7 == F7_ALT);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic string kind_name(input logic [31:0] ins);
        if (!is_legal(ins)) return "illegal";
        if (is_mul_op(ins)) return "mul";
        if (ins[6:0] == OPC_LUI) return "lui";
        return "alu";
    endfunction

    // expected result of a legal instruction from its source values
    function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] rs2_val);
        logic [31:0] b;
        logic [4:0]  sh;
        if (ins[6:0] == OPC_LUI) return {ins[31:12], 12'b0};
        b = (ins[6:0] == OPC_IMM) ? {{20{ins[31]}}, ins[31:20]} : rs2_val;
        sh = b[4:0];
        if (is_mul_op(ins)) return a * b;
        case (ins[14:12])
            3'd0:    return (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return ins[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] ins;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [3:0]  sel;
        logic [6:0]  op;
        logic        alt;
        // all-ones, a lone sign bit, then mul corner cases
        prog.push_back(enc(7'h7f, 5'h1f, 5'd0, 3'd0, 5'd1, OPC_IMM));
        prog.push_back({20'h80000, 5'd2, OPC_LUI});
        prog.push_back(enc(F7_MUL, 5'd1, 5'd1, 3'd0, 5'd3, OPC_OP));
        prog.push_back(enc(F7_MUL, 5'd0, 5'd1, 3'd0, 5'd4, OPC_OP));
        prog.push_back(enc(F7_MUL, 5'd1, 5'd2, 3'd0, 5'd5, OPC_OP));
        prog.push_back(enc(F7_MUL, 5'd2, 5'd5, 3'd0, 5'd0, OPC_OP));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            next_rand(r);
            // x0..x7 only, so back-to-back dependencies are common
            rd = {2'b0, r[2:0]};
            rs1 = {2'b0, r[5:3]};
            rs2 = {2'b0, r[8:6]};
            f3 = r[11:9];
            imm = r[23:12];
            sel = r[27:24];
            alt = r[28] && (f3 == 3'd0 || f3 == 3'd5);
            if (sel < 4'd6) begin
                ins = enc(alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OPC_OP);
            end else if (sel == 4'd10) begin
                ins = {r[31:12], rd, OPC_LUI};
            end else if (sel == 4'd11 || sel == 4'd12) begin
                ins = enc(F7_MUL, rs2, rs1, 3'd0, rd, OPC_OP);
            end else if (sel == 4'd13) begin
                next_rand(r2);
                op = r2[6:0];
                if (op == OPC_OP || op == OPC_IMM || op == OPC_LUI) op = op ^ 7'b1000000;
                case (r2[8:7])
                    2'd0:    ins = enc(r2[15:9], rs2, rs1, f3, rd, op);
                    2'd1:    ins = enc(7'b0000010, rs2, rs1, f3, rd, OPC_OP);
                    2'd2:    ins = enc(F7_ALT, rs2, rs1, r2[16] ? 3'd6 : 3'd1, rd, OPC_OP);
                    default: ins = enc(F7_MUL, rs2, rs1, f3 | 3'd1, rd, OPC_OP);
                endcase
            end else begin
                if (f3 == 3'd1) imm[11:5] = F7_BASE;
                if (f3 == 3'd5) imm[11:5] = alt ? F7_ALT : F7_BASE;
                ins = enc(imm[11:5], imm[4:0], rs1, f3, rd, OPC_IMM);
            end
            prog.push_back(ins);
        end
    endtask

    // one clock: busy checks at negedge, then the register model for the edge
    task automatic tick(output logic consumed);
        logic        b;
        logic        legal;
        logic [31:0] res;
        @(negedge CLK);
        b = busy;
        if (instr_valid && is_legal(instr) && is_mul_op(instr)) begin
            if (mul_first && !b) fail_run("busy did not rise in the first cycle of a MUL");
            if (b) busy_cycles++;
            if (busy_cycles > MUL_BUSY_MAX) fail_run("busy stayed high too long for one MUL");
        end else if (b) begin
            fail_run("busy is high while no legal MUL is in execute");
        end
        mul_first = 1'b0;
        @(posedge CLK);
        consumed = 1'b0;
        wb_next_en = 1'b0;
        if (stall) begin
            exp_name = "stall";
        end else if (flush) begin
            exp_name = "flush";
            exp_valid = 1'b0;
            exp_rw = 1'b0;
            exp_ill = 1'b0;
            exp_rd = '0;
            exp_res = '0;
            exp_res_known = 1'b1;
            // a running mul survives the flush
            consumed = instr_valid && !b;
        end else if (b) begin
            exp_name = "mul";
            exp_valid = 1'b0;
            exp_rw = 1'b0;
            exp_ill = 1'b0;
        end else begin
            legal = is_legal(instr);
            res = ref_result(instr, model[instr[19:15]], model[instr[24:20]]);
            exp_name = kind_name(instr);
            exp_valid = instr_valid;
            exp_ill = instr_valid && !legal;
            exp_rw = instr_valid && legal && (instr[11:7] != 5'd0);
            exp_rd = instr[11:7];
            exp_res = res;
            exp_res_known = instr_valid && legal;
            consumed = instr_valid;
            if (exp_rw) begin
                model[instr[11:7]] = res;
                wb_next_en = 1'b1;
                wb_next_rd = instr[11:7];
                wb_next_data = res;
            end
        end
    endtask

    // compare the pipeline register against the model every cycle
    always @(negedge CLK) begin
        if (checking) begin
            check("ex_valid", {31'b0, exp_valid}, {31'b0, ex_valid});
            check("ex_reg_write", {31'b0, exp_rw}, {31'b0, ex_reg_write});
            check("ex_illegal", {31'b0, exp_ill}, {31'b0, ex_illegal});
            check("ex_rd", {27'b0, exp_rd}, {27'b0, ex_rd});
            if (exp_res_known) check("ex_result", exp_res, ex_result);
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        logic        consumed;
        logic [31:0] r;
        int          idx;
        CLK = 1'b0;
        nRST = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        {exp_valid, exp_rw, exp_ill, exp_rd, exp_res} = '0;
        exp_res_known = 1'b1;
        wb_next_rd = '0;
        wb_next_data = '0;
        stall_left = 0;
        busy_cycles = 0;
        foreach (model[i]) model[i] = '0;
        build_program();
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        checking = 1'b1;
        @(negedge CLK);
        check("busy", 32'd0, {31'b0, busy});
        @(posedge CLK);
        instr <= prog[0];
        instr_valid <= 1'b1;
        mul_first = 1'b1;
        idx = 0;
        while (idx < NUM_INSTR) begin
            tick(consumed);
            wb_en <= wb_next_en;
            wb_rd <= wb_next_rd;
            wb_data <= wb_next_data;
            if (consumed) begin
                idx++;
                mul_first = 1'b1;
                busy_cycles = 0;
                if (idx < NUM_INSTR) instr <= prog[idx];
                else instr_valid <= 1'b0;
            end
            next_rand(r);
            // random stall stretches of 1 to 4 cycles, rare flushes
            if (idx >= NUM_INSTR) begin
                stall <= 1'b0;
                flush <= 1'b0;
            end else if (stall_left > 0) begin
                stall_left--;
                stall <= 1'b1;
                flush <= r[9];
            end else if (r[2:0] == 3'd0) begin
                stall_left = int'(r[5:4]);
                stall <= 1'b1;
                flush <= r[9];
            end else begin
                stall <= 1'b0;
                flush <= (r[7:4] == 4'd0);
            end
        end
        repeat (3) begin
            tick(consumed);
            wb_en <= wb_next_en;
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
